//--- hdl/mem_port_pkg.sv
`default_nettype none

package mem_port_pkg;

   // Byte address into main memory.
   localparam int MEM_ADDR_BITS = 30;

   // One data beat on the write and read FIFOs.
   localparam int MEM_DATA_BITS = 32;

   localparam int MEM_BL_BITS   = 6;  // Burst length minus one.

   localparam int MEM_CMD_BITS  = 3;

   // Command opcodes understood by the controller.
   typedef enum logic [MEM_CMD_BITS-1:0] {
      CMD_WRITE = 3'b000,
      CMD_READ  = 3'b001
   } mem_cmd_e;

endpackage

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;
   import mem_port_pkg::*;

   localparam int ADDR_BITS     = 16;             // Instruction pointer, byte address.
   localparam int INSTR_BITS    = MEM_DATA_BITS;  // One instruction per memory word.
   localparam int BYTE_OFS_BITS = 2;
   localparam int WORD_IDX_BITS = ADDR_BITS - BYTE_OFS_BITS;

   // Upper address bits that place the program region in main memory.
   localparam int PREFIX_BITS = MEM_ADDR_BITS - ADDR_BITS;
   localparam logic [PREFIX_BITS-1:0] MAIN_MEM_PREFIX = 14'h0001;

   typedef enum logic [1:0] {
      PRE_BOOT,
      CMD,
      WAIT,  // Read issued and data not back yet.
      READ
   } cache_state_e;

   typedef enum logic [1:0] {
      IDLE,
      WRITE_DATA,
      WRITE_CMD,
      DONE
   } boot_state_e;

endpackage

`default_nettype wire

//--- hdl/mem_port_if.sv
`default_nettype none

interface mem_port_if;
   import mem_port_pkg::*;

   // Command FIFO.
   logic                     cmd_en;
   mem_cmd_e                 cmd_instr;
   logic [MEM_BL_BITS-1:0]   cmd_bl;
   logic [MEM_ADDR_BITS-1:0] cmd_byte_addr;
   logic                     cmd_full;

   // Write data FIFO.
   logic                     wr_en;
   logic [MEM_DATA_BITS-1:0] wr_data;
   logic                     wr_full;

   // Read data FIFO.
   logic                     rd_en;
   logic [MEM_DATA_BITS-1:0] rd_data;  // Head word, valid while not empty.
   logic                     rd_empty;

   modport master (
      output cmd_en, cmd_instr, cmd_bl, cmd_byte_addr,
      output wr_en, wr_data,
      output rd_en,
      input  cmd_full, wr_full,
      input  rd_data, rd_empty
   );

   modport slave (
      input  cmd_en, cmd_instr, cmd_bl, cmd_byte_addr,
      input  wr_en, wr_data,
      input  rd_en,
      output cmd_full, wr_full,
      output rd_data, rd_empty
   );

endinterface

`default_nettype wire

//--- hdl/instr_cache.sv
`default_nettype none

module instr_cache (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             boot_done,

   // Fetch request and result.
   input  logic [fetch_pkg::ADDR_BITS-1:0]  instr_ptr,
   output logic                             valid,
   output logic [fetch_pkg::INSTR_BITS-1:0] instr,

   // Memory port routed through the boot loader.
   mem_port_if.master                       mem
);
   import mem_port_pkg::*;
   import fetch_pkg::*;

   cache_state_e             state;
   logic [MEM_ADDR_BITS-1:0] prefixed_ptr;
   logic [MEM_ADDR_BITS-1:0] cur_addr;    // Address of the word in instr.
   logic                     need_read;
   logic                     cmd_accept;

   assign prefixed_ptr = {MAIN_MEM_PREFIX, instr_ptr};

   // Hit only when idle and the held word is the one asked for.
   assign valid = (state == CMD) && (cur_addr == prefixed_ptr);

   always_comb begin
      case (state)
         PRE_BOOT: need_read = boot_done;
         CMD:      need_read = (cur_addr != prefixed_ptr);
         default:  need_read = 1'b0;
      endcase
   end

   // A read goes out on the first cycle the command FIFO has room.
   assign cmd_accept = need_read && !mem.cmd_full;

   assign mem.cmd_en        = cmd_accept;
   assign mem.cmd_instr     = CMD_READ;
   assign mem.cmd_bl        = '0;  // Single word.
   assign mem.cmd_byte_addr = prefixed_ptr;

   // The write FIFO is never touched.
   assign mem.wr_en   = 1'b0;
   assign mem.wr_data = '0;

   // Pop the head word while it is being captured.
   assign mem.rd_en = (state == READ);

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= PRE_BOOT;
         cur_addr <= '0;
         instr    <= '0;
      end else begin
         case (state)
            PRE_BOOT, CMD: begin
               if (cmd_accept) begin
                  cur_addr <= prefixed_ptr;
                  state    <= WAIT;
               end
            end
            WAIT: begin
               if (!mem.rd_empty) begin
                  state <= READ;
               end
            end
            READ: begin
               instr <= mem.rd_data;  // Word popped this cycle.
               state <= CMD;
            end
            default: state <= PRE_BOOT;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/boot_loader.sv
`default_nettype none

module boot_loader (
   input  logic                             clk,
   input  logic                             reset,

   // Boot image stream.
   input  logic                             load_valid,
   input  logic [fetch_pkg::INSTR_BITS-1:0] load_data,
   input  logic                             load_last,
   output logic                             load_busy,
   output logic                             boot_done,

   // Port seen by the cache.
   mem_port_if.slave                        cache,

   // Port toward the memory controller.
   mem_port_if.master                       mem
);
   import mem_port_pkg::*;
   import fetch_pkg::*;

   boot_state_e              state;
   logic [INSTR_BITS-1:0]    word_data;
   logic                     word_last;
   logic [WORD_IDX_BITS-1:0] word_idx;   // Next word slot in the region.
   logic [MEM_ADDR_BITS-1:0] word_addr;
   logic                     wr_push;
   logic                     cmd_accept;

   assign word_addr  = {MAIN_MEM_PREFIX, word_idx, {BYTE_OFS_BITS{1'b0}}};
   assign wr_push    = (state == WRITE_DATA) && !mem.wr_full;
   assign cmd_accept = (state == WRITE_CMD) && !mem.cmd_full;

   // Loader owns the port until boot is over, then the cache takes it.
   always_comb begin
      if (boot_done) begin
         mem.cmd_en        = cache.cmd_en;
         mem.cmd_instr     = cache.cmd_instr;
         mem.cmd_bl        = cache.cmd_bl;
         mem.cmd_byte_addr = cache.cmd_byte_addr;
         mem.wr_en         = cache.wr_en;
         mem.wr_data       = cache.wr_data;
         mem.rd_en         = cache.rd_en;
         cache.cmd_full    = mem.cmd_full;
         cache.wr_full     = mem.wr_full;
         cache.rd_empty    = mem.rd_empty;
      end else begin
         mem.cmd_en        = cmd_accept;
         mem.cmd_instr     = CMD_WRITE;
         mem.cmd_bl        = '0;       // One word per command.
         mem.cmd_byte_addr = word_addr;
         mem.wr_en         = wr_push;
         mem.wr_data       = word_data;
         mem.rd_en         = 1'b0;
         // Cache sees a port that cannot take anything yet.
         cache.cmd_full    = 1'b1;
         cache.wr_full     = 1'b1;
         cache.rd_empty    = 1'b1;
      end
      cache.rd_data = mem.rd_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= IDLE;
         load_busy <= 1'b0;
         boot_done <= 1'b0;
         word_idx  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (load_valid) begin
                  load_busy <= 1'b1;
                  state     <= WRITE_DATA;
               end
            end
            WRITE_DATA: begin
               if (wr_push) begin
                  state <= WRITE_CMD;
               end
            end
            WRITE_CMD: begin
               if (cmd_accept) begin
                  load_busy <= 1'b0;
                  word_idx  <= word_idx + 1'b1;
                  if (word_last) begin
                     boot_done <= 1'b1;
                     state     <= DONE;
                  end else begin
                     state <= IDLE;
                  end
               end
            end
            DONE: boot_done <= 1'b1;  // Held until reset.
            default: state <= IDLE;
         endcase
      end
   end

   // Word and its last flag are taken with the strobe.
   always_ff @(posedge clk) begin
      if ((state == IDLE) && load_valid) begin
         word_data <= load_data;
         word_last <= load_last;
      end
   end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`default_nettype none

module fetch_top (
   input  logic                                    clk,
   input  logic                                    reset,

   // Boot image stream.
   input  logic                                    load_valid,
   input  logic [fetch_pkg::INSTR_BITS-1:0]        load_data,
   input  logic                                    load_last,
   output logic                                    load_busy,
   output logic                                    boot_done,

   // Fetch.
   input  logic [fetch_pkg::ADDR_BITS-1:0]         instr_ptr,
   output logic                                    valid,
   output logic [fetch_pkg::INSTR_BITS-1:0]        instr,

   // Memory controller user port.
   output logic                                    mem_cmd_en,
   output logic [mem_port_pkg::MEM_CMD_BITS-1:0]   mem_cmd_instr,
   output logic [mem_port_pkg::MEM_BL_BITS-1:0]    mem_cmd_bl,
   output logic [mem_port_pkg::MEM_ADDR_BITS-1:0]  mem_cmd_byte_addr,
   input  logic                                    mem_cmd_full,
   output logic                                    mem_wr_en,
   output logic [mem_port_pkg::MEM_DATA_BITS-1:0]  mem_wr_data,
   input  logic                                    mem_wr_full,
   output logic                                    mem_rd_en,
   input  logic [mem_port_pkg::MEM_DATA_BITS-1:0]  mem_rd_data,
   input  logic                                    mem_rd_empty
);

   mem_port_if cache_port ();
   mem_port_if mem_port ();

   instr_cache i_instr_cache (
      .clk       (clk),
      .reset     (reset),
      .boot_done (boot_done),
      .instr_ptr (instr_ptr),
      .valid     (valid),
      .instr     (instr),
      .mem       (cache_port.master)
   );

   boot_loader i_boot_loader (
      .clk        (clk),
      .reset      (reset),
      .load_valid (load_valid),
      .load_data  (load_data),
      .load_last  (load_last),
      .load_busy  (load_busy),
      .boot_done  (boot_done),
      .cache      (cache_port.slave),
      .mem        (mem_port.master)
   );

   // Controller side out to the pins.
   assign mem_cmd_en        = mem_port.cmd_en;
   assign mem_cmd_instr     = mem_port.cmd_instr;
   assign mem_cmd_bl        = mem_port.cmd_bl;
   assign mem_cmd_byte_addr = mem_port.cmd_byte_addr;
   assign mem_wr_en         = mem_port.wr_en;
   assign mem_wr_data       = mem_port.wr_data;
   assign mem_rd_en         = mem_port.rd_en;

   assign mem_port.cmd_full = mem_cmd_full;
   assign mem_port.wr_full  = mem_wr_full;
   assign mem_port.rd_data  = mem_rd_data;
   assign mem_port.rd_empty = mem_rd_empty;

endmodule

`default_nettype wire

//--- dv/mem_ctrl_model.sv
`default_nettype none

module mem_ctrl_model (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   stall_en,  // Allows random full flags.

   input  logic                                   cmd_en,
   input  logic [mem_port_pkg::MEM_CMD_BITS-1:0]  cmd_instr,
   input  logic [mem_port_pkg::MEM_ADDR_BITS-1:0] cmd_byte_addr,
   output logic                                   cmd_full,
   input  logic                                   wr_en,
   input  logic [mem_port_pkg::MEM_DATA_BITS-1:0] wr_data,
   output logic                                   wr_full,
   input  logic                                   rd_en,
   output logic [mem_port_pkg::MEM_DATA_BITS-1:0] rd_data,
   output logic                                   rd_empty
);
   import mem_port_pkg::*;

   localparam int MAX_LATENCY = 8;

   // Word storage keyed by byte address divided by 4.
   logic [MEM_DATA_BITS-1:0] words [logic [MEM_ADDR_BITS-3:0]];
   logic [MEM_DATA_BITS-1:0] wr_fifo [$];
   logic [MEM_DATA_BITS-1:0] rd_fifo [$];
   logic [MEM_DATA_BITS-1:0] pend_data [$];  // Reads on their way back.
   int                       pend_due [$];
   int                       now;
   int                       last_due;

   always @(posedge clk) begin : ctrl
      logic [MEM_ADDR_BITS-3:0] word_idx;
      int                       due;
      if (reset) begin
         wr_fifo.delete();
         rd_fifo.delete();
         pend_data.delete();
         pend_due.delete();
         now      = 0;
         last_due = 0;
         cmd_full <= 1'b0;
         wr_full  <= 1'b0;
         rd_empty <= 1'b1;
         rd_data  <= '0;
      end else begin
         now++;
         if (rd_en && (rd_fifo.size() > 0)) begin
            void'(rd_fifo.pop_front());  // Head was on rd_data this cycle.
         end
         if (wr_en && !wr_full) begin
            wr_fifo.push_back(wr_data);
         end
         // Every command moves one word.
         if (cmd_en && !cmd_full) begin
            word_idx = cmd_byte_addr[MEM_ADDR_BITS-1:2];
            if ((cmd_instr == CMD_WRITE) && (wr_fifo.size() > 0)) begin
               words[word_idx] = wr_fifo.pop_front();
            end else if (cmd_instr == CMD_READ) begin
               due = now + int'($urandom_range(MAX_LATENCY, 1));
               if (due < last_due) begin
                  due = last_due;  // Returns stay in command order.
               end
               last_due = due;
               pend_data.push_back(words.exists(word_idx) ? words[word_idx] : '0);
               pend_due.push_back(due);
            end
         end
         while ((pend_due.size() > 0) && (pend_due[0] <= now)) begin
            rd_fifo.push_back(pend_data.pop_front());
            void'(pend_due.pop_front());
         end
         cmd_full <= stall_en && ($urandom_range(3, 0) == 0);
         wr_full  <= stall_en && ($urandom_range(3, 0) == 0);
         rd_empty <= (rd_fifo.size() == 0);
         if (rd_fifo.size() > 0) begin
            rd_data <= rd_fifo[0];
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/fetch_tb.sv
`default_nettype none

module fetch_tb;
   import mem_port_pkg::*;
   import fetch_pkg::*;

   localparam int NUM_WORDS   = 16;
   localparam int NUM_JUMPS   = 40;
   localparam int NUM_FETCHES = NUM_WORDS + 1 + NUM_JUMPS;
   localparam int MAX_CYCLES  = 200 * NUM_FETCHES + 20 * NUM_WORDS;

   logic                     clk;
   logic                     reset;
   logic                     load_valid;
   logic [INSTR_BITS-1:0]    load_data;
   logic                     load_last;
   logic                     load_busy;
   logic                     boot_done;
   logic [ADDR_BITS-1:0]     instr_ptr;
   logic                     valid;
   logic [INSTR_BITS-1:0]    instr;
   logic                     mem_cmd_en;
   logic [MEM_CMD_BITS-1:0]  mem_cmd_instr;
   logic [MEM_BL_BITS-1:0]   mem_cmd_bl;
   logic [MEM_ADDR_BITS-1:0] mem_cmd_byte_addr;
   logic                     mem_cmd_full;
   logic                     mem_wr_en;
   logic [MEM_DATA_BITS-1:0] mem_wr_data;
   logic                     mem_wr_full;
   logic                     mem_rd_en;
   logic [MEM_DATA_BITS-1:0] mem_rd_data;
   logic                     mem_rd_empty;
   logic                     stall_en;

   logic [INSTR_BITS-1:0]    image [$];  // Boot image with one word per address.
   int                       errors      = 0;
   int                       writes_seen = 0;
   int                       data_seen   = 0;
   int                       reads_seen  = 0;
   int                       fetches     = 0;
   int                       cycles      = 0;

   fetch_top i_fetch_top (.*);

   mem_ctrl_model i_mem_ctrl_model (
      .clk           (clk),
      .reset         (reset),
      .stall_en      (stall_en),
      .cmd_en        (mem_cmd_en),
      .cmd_instr     (mem_cmd_instr),
      .cmd_byte_addr (mem_cmd_byte_addr),
      .cmd_full      (mem_cmd_full),
      .wr_en         (mem_wr_en),
      .wr_data       (mem_wr_data),
      .wr_full       (mem_wr_full),
      .rd_en         (mem_rd_en),
      .rd_data       (mem_rd_data),
      .rd_empty      (mem_rd_empty)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_error(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
      $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      errors++;
   endtask

   task automatic print_counts();
      $display("errors %0d, write commands %0d, read commands %0d, fetches %0d",
               errors, writes_seen, reads_seen, fetches);
   endtask

   // Port monitor for every accepted command and write word.
   always @(posedge clk) begin
      if (!reset) begin
         if (mem_cmd_en && mem_cmd_full) begin
            $display("error at %0t: command raised while cmd_full is high", $time);
            errors++;
         end
         if (mem_wr_en && !mem_wr_full) begin
            if (data_seen >= image.size()) begin
               $display("error at %0t: more write words than the image holds", $time);
               errors++;
            end else if (mem_wr_data !== image[data_seen]) begin
               report_error("mem_wr_data", 64'(mem_wr_data), 64'(image[data_seen]));
            end
            data_seen++;
         end
         if (mem_cmd_en && !mem_cmd_full) begin
            if (mem_cmd_instr == CMD_WRITE) begin
               if (mem_cmd_byte_addr !== {MAIN_MEM_PREFIX, WORD_IDX_BITS'(writes_seen), 2'b00})
                  report_error("mem_cmd_byte_addr", 64'(mem_cmd_byte_addr),
                               64'({MAIN_MEM_PREFIX, WORD_IDX_BITS'(writes_seen), 2'b00}));
               writes_seen++;
            end else begin
               if (!boot_done) begin
                  $display("error at %0t: read command issued before boot_done", $time);
                  errors++;
               end
               if (mem_cmd_instr !== CMD_READ)
                  report_error("mem_cmd_instr", 64'(mem_cmd_instr), 64'(CMD_READ));
               if (mem_cmd_bl !== '0)
                  report_error("mem_cmd_bl", 64'(mem_cmd_bl), 64'(0));
               if (mem_cmd_byte_addr !== {MAIN_MEM_PREFIX, instr_ptr})
                  report_error("mem_cmd_byte_addr", 64'(mem_cmd_byte_addr),
                               64'({MAIN_MEM_PREFIX, instr_ptr}));
               reads_seen++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Run stopped after %0d cycles with tests still waiting", cycles);
         print_counts();
         $display("Verification failed");
         $finish;
      end
   end

   task automatic reset_test();
      repeat (10) begin
         @(posedge clk);
         if (valid !== 1'b0) report_error("valid", 64'(valid), 64'(0));
         if (boot_done !== 1'b0) report_error("boot_done", 64'(boot_done), 64'(0));
         if (load_busy !== 1'b0) report_error("load_busy", 64'(load_busy), 64'(0));
         if (mem_cmd_en !== 1'b0) report_error("mem_cmd_en", 64'(mem_cmd_en), 64'(0));
         if (mem_wr_en !== 1'b0) report_error("mem_wr_en", 64'(mem_wr_en), 64'(0));
         if (mem_rd_en !== 1'b0) report_error("mem_rd_en", 64'(mem_rd_en), 64'(0));
         if (instr !== '0) report_error("instr", 64'(instr), 64'(0));
      end
   endtask

   task automatic load_image();
      stall_en <= 1'b1;
      for (int i = 0; i < NUM_WORDS; i++) begin
         @(posedge clk);
         while (load_busy) @(posedge clk);
         load_valid <= 1'b1;
         load_data  <= image[i];
         load_last  <= (i == NUM_WORDS - 1);
         @(posedge clk);
         load_valid <= 1'b0;
         load_last  <= 1'b0;
      end
      @(posedge clk);
      while (!boot_done) @(posedge clk);
      // First cycle of boot_done follows the last write command.
      if (writes_seen != NUM_WORDS)
         report_error("write commands", 64'(writes_seen), 64'(NUM_WORDS));
      if (data_seen != NUM_WORDS)
         report_error("write words", 64'(data_seen), 64'(NUM_WORDS));
      stall_en <= 1'b0;
   endtask

   task automatic fetch_word(input int idx);
      @(posedge clk);
      instr_ptr <= ADDR_BITS'(idx * 4);
      @(posedge clk);
      while (valid !== 1'b1) @(posedge clk);
      if (instr !== image[idx]) report_error("instr", 64'(instr), 64'(image[idx]));
      fetches++;
   endtask

   task automatic sequential_test();
      for (int i = 0; i < NUM_WORDS; i++) begin
         fetch_word(i);
      end
   endtask

   task automatic hold_test();
      int reads_before;
      fetch_word(5);
      reads_before = reads_seen;
      repeat (30) begin
         @(posedge clk);
         if (valid !== 1'b1) report_error("valid", 64'(valid), 64'(1));
         if (instr !== image[5]) report_error("instr", 64'(instr), 64'(image[5]));
      end
      if (reads_seen != reads_before)
         report_error("read commands", 64'(reads_seen), 64'(reads_before));
   endtask

   task automatic random_test();
      int idx;
      stall_en <= 1'b1;
      for (int n = 0; n < NUM_JUMPS; n++) begin
         idx = int'($urandom_range(NUM_WORDS - 1, 0));
         fetch_word(idx);
      end
      stall_en <= 1'b0;
   endtask

   initial begin
      void'($urandom(20));
      reset      = 1'b1;
      load_valid = 1'b0;
      load_data  = '0;
      load_last  = 1'b0;
      instr_ptr  = '0;
      stall_en   = 1'b0;
      for (int i = 0; i < NUM_WORDS; i++) begin
         image.push_back($urandom);
      end
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      reset_test();
      load_image();
      sequential_test();
      hold_test();
      random_test();

      print_counts();
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
hdl/mem_port_pkg.sv
hdl/fetch_pkg.sv
hdl/mem_port_if.sv
hdl/instr_cache.sv
hdl/boot_loader.sv
hdl/fetch_top.sv
dv/mem_ctrl_model.sv
dv/fetch_tb.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing -j 0
TOP       := fetch_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
